//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_top
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, and search $(LOG) for the pass message"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "variables: VERILATOR TOP FLIST BUILD_DIR LOG VFLAGS"

$(BUILD_DIR)/V$(TOP): $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FLIST)

test: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -qxF '*** PASSED ***' $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- flist.f
source/hps_bus_pkg.sv
source/io_map_pkg.sv
source/hps_frame.sv
source/control_regs.sv
source/status_exchange.sv
source/ps2_key_decoder.sv
source/file_loader.sv
source/hps_io_top.sv
verification/tb_checker.sv
verification/tb_top.sv

//--- source/control_regs.sv
`timescale 1ns/1ps
`default_nettype none

module control_regs import hps_bus_pkg::*, io_map_pkg::*; #(
	parameter int NUM_JOY = 2
) (
	input  wire logic      clk_sys,
	input  wire logic      arst_n,
	input  wire bus_word_t uio_word,
	output logic [1:0]     buttons,
	output logic           forced_scandoubler,
	output joy_t           joystick [NUM_JOY],
	output logic [63:0]    status
);

	localparam logic [HPS_WORD_W-1:0] JOY_CMD [2] = '{CMD_JOY0, CMD_JOY1};

	logic [HPS_WORD_W-1:0] cfg_q;
	logic                  data_word;

	assign data_word = uio_word.valid && (uio_word.idx != '0);

	// other cfg bits belong to the system side
	assign buttons            = cfg_q[1:0];
	assign forced_scandoubler = cfg_q[4];

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			cfg_q  <= '0;
			status <= '0;
		end else if (data_word) begin
			if (uio_word.cmd == CMD_CFG)
				cfg_q <= uio_word.data.raw;
			if (uio_word.cmd == CMD_STATUS) begin
				// least significant word first
				case (uio_word.idx)
					WORD_IDX_W'(1): status[15:0]  <= uio_word.data.raw;
					WORD_IDX_W'(2): status[31:16] <= uio_word.data.raw;
					WORD_IDX_W'(3): status[47:32] <= uio_word.data.raw;
					WORD_IDX_W'(4): status[63:48] <= uio_word.data.raw;
					default: ;
				endcase
			end
		end
	end

	////////////////////
	// joysticks, low half then high half
	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			for (int j = 0; j < NUM_JOY; j++)
				joystick[j] <= '0;
		end else if (data_word) begin
			for (int j = 0; j < NUM_JOY; j++) begin
				if (uio_word.cmd == JOY_CMD[j]) begin
					if (uio_word.idx == WORD_IDX_W'(1))
						joystick[j][15:0] <= uio_word.data.raw;
					else if (uio_word.idx == WORD_IDX_W'(2))
						joystick[j][31:16] <= uio_word.data.raw;
				end
			end
		end
	end

endmodule

`default_nettype wire

//--- source/file_loader.sv
`timescale 1ns/1ps
`default_nettype none

module file_loader import hps_bus_pkg::*, io_map_pkg::*; #(
	parameter int IOCTL_ADDR_W = 27
) (
	input  wire logic      clk_sys,
	input  wire logic      arst_n,
	input  wire bus_word_t fio_word,
	input  wire logic      ioctl_wait,
	output ioctl_t         ioctl,
	output logic           hps_wait
);

	logic                    download_q;
	logic                    wr_q;
	logic [15:0]             index_q;
	logic [31:0]             file_ext_q;
	logic [IOCTL_ADDR_W-1:0] next_addr_q;
	logic [IOCTL_ADDR_W-1:0] addr_q;
	logic [7:0]              dout_q;
	logic                    data_word;
	logic                    flag_word;
	logic [7:0]              tx_flag;
	logic                    start_dl;
	logic                    stop_dl;
	logic                    dat_wr;

	////////////////////
	// command decode
	assign data_word = fio_word.valid && (fio_word.idx != '0);
	assign flag_word = data_word && (fio_word.cmd == FIO_FILE_TX) &&
		(fio_word.idx == WORD_IDX_W'(1));
	assign tx_flag   = fio_word.data.raw[7:0];
	// upload mark falls through both
	assign start_dl  = flag_word && (tx_flag != 8'h00) && (tx_flag != UPLOAD_MARK);
	assign stop_dl   = flag_word && (tx_flag == 8'h00);
	assign dat_wr    = data_word && (fio_word.cmd == FIO_FILE_TX_DAT) && download_q;

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			download_q <= 1'b0;
			wr_q       <= 1'b0;
		end else begin
			wr_q <= dat_wr;
			if (start_dl)
				download_q <= 1'b1;
			else if (stop_dl)
				download_q <= 1'b0;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (data_word) begin
			case (fio_word.cmd)
				FIO_FILE_INDEX: index_q <= fio_word.data.raw;
				FIO_FILE_INFO: begin
					// extension arrives upper word first
					if (fio_word.idx == WORD_IDX_W'(1))
						file_ext_q[31:16] <= fio_word.data.raw;
					else if (fio_word.idx == WORD_IDX_W'(2))
						file_ext_q[15:0] <= fio_word.data.raw;
				end
				FIO_FILE_TX: begin
					case (fio_word.idx)
						WORD_IDX_W'(1): begin
							if (start_dl)
								next_addr_q <= '0;
						end
						WORD_IDX_W'(2): begin
							next_addr_q[15:0] <= fio_word.data.raw;
							addr_q[15:0]      <= fio_word.data.raw;
						end
						WORD_IDX_W'(3): begin
							next_addr_q[IOCTL_ADDR_W-1:16] <= fio_word.data.raw[IOCTL_ADDR_W-17:0];
							addr_q[IOCTL_ADDR_W-1:16]      <= fio_word.data.raw[IOCTL_ADDR_W-17:0];
						end
						default: ;
					endcase
				end
				FIO_FILE_TX_DAT: begin
					if (download_q) begin
						addr_q      <= next_addr_q;
						dout_q      <= fio_word.data.raw[7:0];
						next_addr_q <= next_addr_q + 1'b1;
					end
				end
				default: ;
			endcase
		end
	end

	assign ioctl = '{
		download: download_q,
		wr:       wr_q,
		index:    index_q,
		file_ext: file_ext_q,
		addr:     IOCTL_ADDR_MAX_W'(addr_q),
		dout:     dout_q
	};

	// no buffering, the host itself holds off while the core stalls
	assign hps_wait = ioctl_wait;

	a_wr_in_download: assert property (@(posedge clk_sys) disable iff (!arst_n)
		ioctl.wr |-> ioctl.download);

	a_no_word_in_wait: assert property (@(posedge clk_sys) disable iff (!arst_n)
		fio_word.valid |-> !$past(ioctl_wait));

endmodule

`default_nettype wire

//--- source/hps_bus_pkg.sv
`default_nettype none

package hps_bus_pkg;

	localparam int HPS_WORD_W = 16;
	// word index within a frame, saturates at all ones
	localparam int WORD_IDX_W = 4;

	// raw host inputs, sampled on clk_sys
	typedef struct packed {
		logic                  io_strobe;
		logic                  io_enable;
		logic                  fp_enable;
		logic [HPS_WORD_W-1:0] io_din;
	} bus_in_t;

	// keyboard word, marker of all ones ends the useful part of a frame
	typedef struct packed {
		logic [7:0] marker;
		logic [7:0] code;
	} ps2_byte_t;

	typedef union packed {
		logic [HPS_WORD_W-1:0] raw;
		ps2_byte_t             ps2;
	} hps_word_u;

	// one accepted word, idx 0 carries the command itself
	typedef struct packed {
		logic                  valid;
		logic [WORD_IDX_W-1:0] idx;
		logic [HPS_WORD_W-1:0] cmd;
		hps_word_u             data;
	} bus_word_t;

	////////////////////
	// user-I/O channel commands
	localparam logic [HPS_WORD_W-1:0] CMD_CFG        = 16'h0001;
	localparam logic [HPS_WORD_W-1:0] CMD_JOY0       = 16'h0002;
	localparam logic [HPS_WORD_W-1:0] CMD_JOY1       = 16'h0003;
	localparam logic [HPS_WORD_W-1:0] CMD_KBD        = 16'h0005;
	localparam logic [HPS_WORD_W-1:0] CMD_STATUS     = 16'h001E;
	localparam logic [HPS_WORD_W-1:0] CMD_STATUS_REQ = 16'h0029;

	////////////////////
	// file channel commands
	localparam logic [HPS_WORD_W-1:0] FIO_FILE_TX     = 16'h0053;
	localparam logic [HPS_WORD_W-1:0] FIO_FILE_TX_DAT = 16'h0054;
	localparam logic [HPS_WORD_W-1:0] FIO_FILE_INDEX  = 16'h0055;
	localparam logic [HPS_WORD_W-1:0] FIO_FILE_INFO   = 16'h0056;

	// upload start flag, not supported here
	localparam logic [7:0] UPLOAD_MARK = 8'hAA;

endpackage

`default_nettype wire

//--- source/hps_frame.sv
`timescale 1ns/1ps
`default_nettype none

module hps_frame import hps_bus_pkg::*; (
	input  wire logic    clk_sys,
	input  wire logic    arst_n,
	input  wire bus_in_t bus_in,
	output bus_word_t    uio_word,
	output bus_word_t    fio_word,
	output logic         uio_end
);

	logic [1:0] ch_en;
	bus_word_t  ch_word [2];
	logic       io_en_d;

	// channel 0 is user-I/O, channel 1 is file
	assign ch_en = {bus_in.fp_enable, bus_in.io_enable};

	for (genvar ch = 0; ch < 2; ch++) begin : g_ch
		logic [WORD_IDX_W-1:0] cnt_q;
		logic [HPS_WORD_W-1:0] cmd_q;
		logic                  valid_q;
		logic [WORD_IDX_W-1:0] idx_q;
		hps_word_u             data_q;
		logic                  take;

		assign take = ch_en[ch] & bus_in.io_strobe;

		always_ff @(posedge clk_sys or negedge arst_n) begin
			if (!arst_n) begin
				cnt_q   <= '0;
				cmd_q   <= '0;
				valid_q <= 1'b0;
			end else begin
				valid_q <= take;
				// enable low restarts the frame
				if (!ch_en[ch]) begin
					cnt_q <= '0;
				end else if (take) begin
					if (cnt_q == '0)
						cmd_q <= bus_in.io_din;
					if (cnt_q != '1)
						cnt_q <= cnt_q + 1'b1;
				end
			end
		end

		always_ff @(posedge clk_sys) begin
			if (take) begin
				idx_q      <= cnt_q;
				data_q.raw <= bus_in.io_din;
			end
		end

		assign ch_word[ch] = {valid_q, idx_q, cmd_q, data_q};
	end

	assign uio_word = ch_word[0];
	assign fio_word = ch_word[1];

	////////////////////
	// end of user-I/O frame
	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			io_en_d <= 1'b0;
			uio_end <= 1'b0;
		end else begin
			io_en_d <= bus_in.io_enable;
			uio_end <= io_en_d & ~bus_in.io_enable;
		end
	end

	a_one_channel: assert property (@(posedge clk_sys) disable iff (!arst_n)
		!(bus_in.io_enable && bus_in.fp_enable));

endmodule

`default_nettype wire

//--- source/hps_io_top.sv
`timescale 1ns/1ps
`default_nettype none

module hps_io_top import hps_bus_pkg::*, io_map_pkg::*; #(
	parameter int NUM_JOY      = 2,
	parameter int IOCTL_ADDR_W = 27
) (
	input  wire logic             clk_sys,
	input  wire logic             arst_n,
	// host side
	input  wire bus_in_t          bus_in,
	output logic [HPS_WORD_W-1:0] hps_dout,
	output logic                  hps_wait,
	// core side
	input  wire logic [63:0]      status_in,
	input  wire logic             status_set,
	input  wire logic             ioctl_wait,
	output logic [1:0]            buttons,
	output logic                  forced_scandoubler,
	output joy_t                  joystick [NUM_JOY],
	output logic [63:0]           status,
	output ps2_key_t              ps2_key,
	output ioctl_t                ioctl
);

	bus_word_t uio_word;
	bus_word_t fio_word;
	logic      uio_end;

	////////////////////
	// framing
	hps_frame hps_frame_i (
		.clk_sys  (clk_sys),
		.arst_n   (arst_n),
		.bus_in   (bus_in),
		.uio_word (uio_word),
		.fio_word (fio_word),
		.uio_end  (uio_end)
	);

	////////////////////
	// user-I/O consumers
	control_regs #(
		.NUM_JOY (NUM_JOY)
	) control_regs_i (
		.clk_sys            (clk_sys),
		.arst_n             (arst_n),
		.uio_word           (uio_word),
		.buttons            (buttons),
		.forced_scandoubler (forced_scandoubler),
		.joystick           (joystick),
		.status             (status)
	);

	status_exchange status_exchange_i (
		.clk_sys    (clk_sys),
		.arst_n     (arst_n),
		.uio_word   (uio_word),
		.status_in  (status_in),
		.status_set (status_set),
		.hps_dout   (hps_dout)
	);

	ps2_key_decoder ps2_key_decoder_i (
		.clk_sys  (clk_sys),
		.arst_n   (arst_n),
		.uio_word (uio_word),
		.uio_end  (uio_end),
		.ps2_key  (ps2_key)
	);

	// file channel
	file_loader #(
		.IOCTL_ADDR_W (IOCTL_ADDR_W)
	) file_loader_i (
		.clk_sys    (clk_sys),
		.arst_n     (arst_n),
		.fio_word   (fio_word),
		.ioctl_wait (ioctl_wait),
		.ioctl      (ioctl),
		.hps_wait   (hps_wait)
	);

endmodule

`default_nettype wire

//--- source/io_map_pkg.sv
`default_nettype none

package io_map_pkg;

	// widest download address the core port carries
	localparam int IOCTL_ADDR_MAX_W = 27;

	typedef logic [31:0] joy_t;

	// toggle flips once per keyboard event
	typedef struct packed {
		logic       toggle;
		logic       pressed;
		logic       extended;
		logic [7:0] code;
	} ps2_key_t;

	typedef struct packed {
		logic                        download;
		logic                        wr;
		logic [15:0]                 index;
		logic [31:0]                 file_ext;
		logic [IOCTL_ADDR_MAX_W-1:0] addr;
		logic [7:0]                  dout;
	} ioctl_t;

	////////////////////
	// scan code prefixes
	localparam logic [7:0] KEY_BREAK_PFX = 8'hF0;
	localparam logic [7:0] KEY_EXT_PFX   = 8'hE0;

	// multi byte sequences with fixed results, as {pressed, extended, code}
	localparam logic [31:0] KEY_PRTSCR_MAKE   = 32'hE012E07C;
	localparam logic [31:0] KEY_PRTSCR_BREAK  = 32'h7CE0F012;
	localparam logic [31:0] KEY_PAUSE_MAKE    = 32'hF014F077;
	localparam logic [9:0]  KEY_PRTSCR_MAKE_F  = 10'h37C;
	localparam logic [9:0]  KEY_PRTSCR_BREAK_F = 10'h17C;
	localparam logic [9:0]  KEY_PAUSE_MAKE_F   = 10'h377;

endpackage

`default_nettype wire

//--- source/ps2_key_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module ps2_key_decoder import hps_bus_pkg::*, io_map_pkg::*; (
	input  wire logic      clk_sys,
	input  wire logic      arst_n,
	input  wire bus_word_t uio_word,
	input  wire logic      uio_end,
	output ps2_key_t       ps2_key
);

	logic [31:0] raw_q;
	logic        skip_q;
	logic        kbd_frame_q;
	logic        kbd_word;
	logic        pressed;
	logic        extended;
	logic [9:0]  key_fields;

	assign kbd_word = uio_word.valid && (uio_word.cmd == CMD_KBD) && (uio_word.idx != '0);

	////////////////////
	// field decode from the last bytes
	always_comb begin
		pressed  = raw_q[15:8] != KEY_BREAK_PFX;
		// release puts F0 between E0 and the code
		extended = pressed ? (raw_q[15:8] == KEY_EXT_PFX) : (raw_q[23:16] == KEY_EXT_PFX);
		case (raw_q)
			KEY_PRTSCR_MAKE:  key_fields = KEY_PRTSCR_MAKE_F;
			KEY_PRTSCR_BREAK: key_fields = KEY_PRTSCR_BREAK_F;
			KEY_PAUSE_MAKE:   key_fields = KEY_PAUSE_MAKE_F;
			default:          key_fields = {pressed, extended, raw_q[7:0]};
		endcase
	end

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			raw_q       <= '0;
			skip_q      <= 1'b0;
			kbd_frame_q <= 1'b0;
			ps2_key     <= '0;
		end else begin
			if (uio_word.valid && (uio_word.idx == '0)) begin
				kbd_frame_q <= (uio_word.cmd == CMD_KBD);
				raw_q       <= '0;
				skip_q      <= 1'b0;
			end else if (kbd_word) begin
				// newest byte enters at the bottom
				if (&uio_word.data.ps2.marker)
					skip_q <= 1'b1;
				else if (!skip_q)
					raw_q <= {raw_q[23:0], uio_word.data.ps2.code};
			end

			// one event per keyboard frame
			if (uio_end && kbd_frame_q) begin
				ps2_key     <= {~ps2_key.toggle, key_fields};
				kbd_frame_q <= 1'b0;
			end
		end
	end

	a_toggle_at_end: assert property (@(posedge clk_sys) disable iff (!arst_n)
		$changed(ps2_key.toggle) |-> $past(uio_end));

endmodule

`default_nettype wire

//--- source/status_exchange.sv
`timescale 1ns/1ps
`default_nettype none

module status_exchange import hps_bus_pkg::*; (
	input  wire logic              clk_sys,
	input  wire logic              arst_n,
	input  wire bus_word_t         uio_word,
	input  wire logic [63:0]       status_in,
	input  wire logic              status_set,
	output logic [HPS_WORD_W-1:0]  hps_dout
);

	logic        status_set_d;
	logic [3:0]  req_cnt_q;
	logic [63:0] status_req_q;

	// request edge bumps the counter the host polls
	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			status_set_d <= 1'b0;
			req_cnt_q    <= '0;
		end else begin
			status_set_d <= status_set;
			if (status_set && !status_set_d)
				req_cnt_q <= req_cnt_q + 4'd1;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (status_set && !status_set_d)
			status_req_q <= status_in;
	end

	////////////////////
	// reply word, valid before the next strobe
	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			hps_dout <= '0;
		end else if (uio_word.valid) begin
			if (uio_word.cmd != CMD_STATUS_REQ) begin
				hps_dout <= '0;
			end else begin
				case (uio_word.idx)
					WORD_IDX_W'(0): hps_dout <= {8'h00, 4'hA, req_cnt_q};
					WORD_IDX_W'(1): hps_dout <= status_req_q[15:0];
					WORD_IDX_W'(2): hps_dout <= status_req_q[31:16];
					WORD_IDX_W'(3): hps_dout <= status_req_q[47:32];
					WORD_IDX_W'(4): hps_dout <= status_req_q[63:48];
					default:        hps_dout <= '0;
				endcase
			end
		end
	end

endmodule

`default_nettype wire

//--- verification/tb_checker.sv
`timescale 1ns/1ps
`default_nettype none

module tb_checker import hps_bus_pkg::*, io_map_pkg::*; (
	input  wire logic        clk_sys,
	input  wire logic        arst_n,
	input  wire bus_in_t     bus_in,
	input  wire logic [63:0] status_in,
	input  wire logic        status_set,
	input  wire logic        hps_wait,
	input  wire logic [15:0] hps_dout,
	input  wire logic [1:0]  buttons,
	input  wire logic        forced_scandoubler,
	input  wire joy_t        joystick [2],
	input  wire logic [63:0] status,
	input  wire ps2_key_t    ps2_key,
	input  wire ioctl_t      ioctl,
	output int               errors,
	output int               checks
);

	string       test_name = "reset";
	logic [3:0]  ucnt = '0;
	logic [3:0]  fcnt = '0;
	logic [15:0] ucmd = '0;
	logic [15:0] fcmd = '0;
	logic        io_en_d = 1'b0;
	logic        fp_en_d = 1'b0;
	logic        set_d = 1'b0;
	// model of the DUT state
	logic [15:0] m_cfg = '0;
	joy_t        m_joy [2] = '{32'h0, 32'h0};
	logic [63:0] m_status = '0;
	logic [63:0] m_cap = 'x;
	logic [3:0]  m_req = '0;
	logic [31:0] m_raw = '0;
	logic        m_skip = 1'b0;
	logic        m_kfrm = 1'b0;
	logic        m_tog = 1'b0;
	logic [15:0] m_index = 'x;
	logic [31:0] m_ext = 'x;
	logic        m_dl = 1'b0;
	logic [26:0] m_addr = '0;
	logic [15:0] m_reply = '0;
	logic [34:0] wr_q [$];
	int          key_wait = 0;
	int          reply_wait = 0;

	initial begin
		errors = 0;
		checks = 0;
	end

	// {pressed, extended, code} from the last four bytes, newest lowest
	function automatic logic [9:0] key_ref(input logic [31:0] raw);
		logic pressed;
		logic extended;
		if (raw == 32'hE012E07C)
			return 10'h37C;
		if (raw == 32'h7CE0F012)
			return 10'h17C;
		if (raw == 32'hF014F077)
			return 10'h377;
		pressed  = raw[15:8] != 8'hF0;
		extended = pressed ? (raw[15:8] == 8'hE0) : (raw[23:16] == 8'hE0);
		return {pressed, extended, raw[7:0]};
	endfunction

	function automatic logic [15:0] reply_ref(input logic [3:0] idx, input logic [3:0] cnt,
		input logic [63:0] cap);
		case (idx)
			4'd0: return {8'h00, 4'hA, cnt};
			4'd1: return cap[15:0];
			4'd2: return cap[31:16];
			4'd3: return cap[47:32];
			4'd4: return cap[63:48];
			default: return 16'h0000;
		endcase
	endfunction

	task automatic compare(input string what, input logic [63:0] exp, input logic [63:0] act);
		checks++;
		if (exp !== act) begin
			errors++;
			$display("FAIL %s %s: expected %h, actual %h", test_name, what, exp, act);
		end
	endtask

	task automatic report(input string msg);
		errors++;
		$display("%s in test %s", msg, test_name);
	endtask

	task automatic uio_in(input logic [3:0] idx, input logic [15:0] w);
		if (idx == 0) begin
			ucmd   = w;
			m_kfrm = (w == CMD_KBD);
			m_raw  = '0;
			m_skip = 1'b0;
		end
		// reply is zero outside a status request
		if (ucmd == CMD_STATUS_REQ)
			m_reply = reply_ref(idx, m_req, m_cap);
		else
			m_reply = 16'h0000;
		reply_wait = 2;
		if (idx == 0)
			return;
		case (ucmd)
			CMD_CFG: m_cfg = w;
			CMD_JOY0, CMD_JOY1: begin
				if (idx == 1)
					m_joy[ucmd == CMD_JOY1][15:0] = w;
				else if (idx == 2)
					m_joy[ucmd == CMD_JOY1][31:16] = w;
			end
			CMD_STATUS: begin
				if (idx <= 4)
					m_status[(int'(idx) - 1) * 16 +: 16] = w;
			end
			CMD_KBD: begin
				if (w[15:8] == 8'hFF)
					m_skip = 1'b1;
				else if (!m_skip)
					m_raw = {m_raw[23:0], w[7:0]};
			end
			default: ;
		endcase
	endtask

	task automatic fio_in(input logic [3:0] idx, input logic [15:0] w);
		if (idx == 0) begin
			fcmd = w;
			return;
		end
		case (fcmd)
			FIO_FILE_INDEX: m_index = w;
			FIO_FILE_INFO: begin
				if (idx == 1)
					m_ext[31:16] = w;
				else if (idx == 2)
					m_ext[15:0] = w;
			end
			FIO_FILE_TX: begin
				if (idx == 1 && w[7:0] == 8'h00) begin
					m_dl = 1'b0;
				end else if (idx == 1 && w[7:0] != 8'hAA) begin
					m_dl   = 1'b1;
					m_addr = '0;
				end else if (idx == 2) begin
					m_addr[15:0] = w;
				end else if (idx == 3) begin
					m_addr[26:16] = w[10:0];
				end
			end
			FIO_FILE_TX_DAT: begin
				if (m_dl) begin
					wr_q.push_back({m_addr, w[7:0]});
					m_addr++;
				end
			end
			default: ;
		endcase
	endtask

	always @(posedge clk_sys) begin
		logic [34:0] exp_wr;
		if (arst_n) begin
			////////////////////
			// delayed checks
			if (key_wait != 0) begin
				if (key_wait == 1)
					compare("ps2_key", {m_tog, key_ref(m_raw)}, ps2_key);
				key_wait--;
			end
			if (reply_wait != 0) begin
				if (reply_wait == 1)
					compare("hps_dout", m_reply, hps_dout);
				reply_wait--;
			end
			if (bus_in.io_strobe && hps_wait)
				report("host strobed while hps_wait was high");
			if (ioctl.wr) begin
				if (!ioctl.download)
					report("write pulse outside a download");
				if (wr_q.size() == 0) begin
					report("write pulse with no write expected");
				end else begin
					exp_wr = wr_q.pop_front();
					compare("ioctl.addr", exp_wr[34:8], ioctl.addr);
					compare("ioctl.dout", exp_wr[7:0], ioctl.dout);
				end
			end

			////////////////////
			// framing, mirrors the host protocol
			if (!bus_in.io_enable) begin
				ucnt = '0;
			end else if (bus_in.io_strobe) begin
				uio_in(ucnt, bus_in.io_din);
				if (ucnt != 4'hF)
					ucnt++;
			end
			if (!bus_in.fp_enable) begin
				fcnt = '0;
			end else if (bus_in.io_strobe) begin
				fio_in(fcnt, bus_in.io_din);
				if (fcnt != 4'hF)
					fcnt++;
			end

			// end of a user-I/O frame
			if (io_en_d && !bus_in.io_enable) begin
				compare("buttons", m_cfg[1:0], buttons);
				compare("forced_scandoubler", m_cfg[4], forced_scandoubler);
				compare("joystick0", m_joy[0], joystick[0]);
				compare("joystick1", m_joy[1], joystick[1]);
				compare("status", m_status, status);
				if (m_kfrm) begin
					m_tog    = ~m_tog;
					m_kfrm   = 1'b0;
					key_wait = 2;
				end
			end
			if (fp_en_d && !bus_in.fp_enable) begin
				compare("ioctl.download", m_dl, ioctl.download);
				if (fcmd == FIO_FILE_INDEX)
					compare("ioctl.index", m_index, ioctl.index);
				if (fcmd == FIO_FILE_INFO)
					compare("ioctl.file_ext", m_ext, ioctl.file_ext);
				if (wr_q.size() != 0)
					report($sformatf("%0d expected writes never arrived", wr_q.size()));
			end
			if (status_set && !set_d) begin
				m_req++;
				m_cap = status_in;
			end
			io_en_d = bus_in.io_enable;
			fp_en_d = bus_in.fp_enable;
			set_d   = status_set;
		end
	end

endmodule

`default_nettype wire

//--- verification/tb_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_top import hps_bus_pkg::*, io_map_pkg::*;;

	// words in all frames below, and the worst cycles per word
	localparam int N_WORDS    = 141;
	localparam int WORD_CYC   = 12;
	localparam int MARGIN_CYC = 2000;
	localparam int TIMEOUT_NS = (N_WORDS * WORD_CYC + MARGIN_CYC) * 10;

	logic        clk_sys = 1'b0;
	logic        arst_n;
	bus_in_t     bus_in;
	logic [63:0] status_in;
	logic        status_set;
	logic        ioctl_wait;
	logic [15:0] hps_dout;
	logic        hps_wait;
	logic [1:0]  buttons;
	logic        forced_scandoubler;
	joy_t        joystick [2];
	logic [63:0] status;
	ps2_key_t    ps2_key;
	ioctl_t      ioctl;
	int          errors;
	int          checks;
	logic [15:0] frame_q [$];
	logic        stall_en;
	logic [26:0] dl_start;
	logic [7:0]  dl_bytes [20];

	always #5 clk_sys = ~clk_sys;

	hps_io_top #(
		.NUM_JOY      (2),
		.IOCTL_ADDR_W (27)
	) hps_io_top_i (
		.clk_sys (clk_sys), .arst_n (arst_n), .bus_in (bus_in),
		.hps_dout (hps_dout), .hps_wait (hps_wait),
		.status_in (status_in), .status_set (status_set), .ioctl_wait (ioctl_wait),
		.buttons (buttons), .forced_scandoubler (forced_scandoubler),
		.joystick (joystick), .status (status), .ps2_key (ps2_key), .ioctl (ioctl)
	);

	tb_checker chk_i (
		.clk_sys (clk_sys), .arst_n (arst_n), .bus_in (bus_in),
		.status_in (status_in), .status_set (status_set), .hps_wait (hps_wait),
		.hps_dout (hps_dout), .buttons (buttons), .forced_scandoubler (forced_scandoubler),
		.joystick (joystick), .status (status), .ps2_key (ps2_key), .ioctl (ioctl),
		.errors (errors), .checks (checks)
	);

	task automatic idle(input int n);
		repeat (n) @(posedge clk_sys);
	endtask

	// gap of 4 to 7 cycles, the core may stall at any point of it
	task automatic put_word(input logic [15:0] w);
		int gap;
		gap = 4 + ($urandom % 4);
		for (int i = 0; i < gap; i++) begin
			@(posedge clk_sys);
			ioctl_wait <= stall_en && ($urandom % 3 == 0);
		end
		@(posedge clk_sys);
		// core releases the stall at random
		while (hps_wait) begin
			ioctl_wait <= ($urandom % 2 == 0);
			@(posedge clk_sys);
		end
		bus_in.io_din    <= w;
		bus_in.io_strobe <= 1'b1;
		@(posedge clk_sys);
		bus_in.io_strobe <= 1'b0;
	endtask

	task automatic send_frame(input bit file_ch);
		@(posedge clk_sys);
		if (file_ch)
			bus_in.fp_enable <= 1'b1;
		else
			bus_in.io_enable <= 1'b1;
		foreach (frame_q[i])
			put_word(frame_q[i]);
		idle(4);
		bus_in.io_enable <= 1'b0;
		bus_in.fp_enable <= 1'b0;
		ioctl_wait       <= 1'b0;
		idle(5);
		frame_q.delete();
	endtask

	task automatic download(input bit stall);
		stall_en = stall;
		frame_q = '{FIO_FILE_TX, 16'h0001, dl_start[15:0], {5'd0, dl_start[26:16]}};
		send_frame(1);
		frame_q = '{FIO_FILE_TX_DAT};
		foreach (dl_bytes[i])
			frame_q.push_back({8'($urandom), dl_bytes[i]});
		send_frame(1);
		frame_q = '{FIO_FILE_TX, 16'h0000};
		send_frame(1);
		// data after the stop must not write
		frame_q = '{FIO_FILE_TX_DAT, 16'($urandom)};
		send_frame(1);
		stall_en = 1'b0;
	endtask

	initial begin
		void'($urandom(32'h8a87ef7b));
		bus_in     = '0;
		status_in  = '0;
		status_set = 1'b0;
		ioctl_wait = 1'b0;
		stall_en   = 1'b0;
		arst_n     = 1'b0;
		idle(8);
		arst_n <= 1'b1;
		idle(4);

		chk_i.test_name = "cfg_joy";
		repeat (4) begin
			frame_q = '{CMD_CFG, 16'($urandom)};
			send_frame(0);
			frame_q = '{CMD_JOY0, 16'($urandom), 16'($urandom)};
			send_frame(0);
			frame_q = '{CMD_JOY1, 16'($urandom), 16'($urandom)};
			send_frame(0);
		end

		chk_i.test_name = "status";
		frame_q = '{CMD_STATUS, 16'($urandom), 16'($urandom), 16'($urandom), 16'($urandom)};
		send_frame(0);
		repeat (2) begin
			@(posedge clk_sys);
			status_in  <= {$urandom, $urandom};
			status_set <= 1'b1;
			@(posedge clk_sys);
			status_set <= 1'b0;
			idle(3);
		end
		frame_q = '{CMD_STATUS_REQ, 16'h0, 16'h0, 16'h0, 16'h0};
		send_frame(0);

		////////////////////
		// keyboard
		chk_i.test_name = "keyboard";
		frame_q = '{CMD_KBD, 16'h001C};
		send_frame(0);
		frame_q = '{CMD_KBD, 16'h00F0, 16'h001C};
		send_frame(0);
		frame_q = '{CMD_KBD, 16'h00E0, 16'h00F0, 16'h0075};
		send_frame(0);
		frame_q = '{CMD_KBD, 16'h00E0, 16'h0012, 16'h00E0, 16'h007C};
		send_frame(0);
		frame_q = '{CMD_KBD, 16'h00E0, 16'h00F0, 16'h007C, 16'h00E0, 16'h00F0, 16'h0012};
		send_frame(0);
		frame_q = '{CMD_KBD, 16'h00E1, 16'h0014, 16'h0077, 16'h00E1,
			16'h00F0, 16'h0014, 16'h00F0, 16'h0077};
		send_frame(0);
		frame_q = '{CMD_KBD, 16'h001C, 16'hFF00, 16'h0033};
		send_frame(0);

		////////////////////
		// downloads, same stream with and without stalls
		dl_start = 27'($urandom);
		foreach (dl_bytes[i])
			dl_bytes[i] = 8'($urandom);
		chk_i.test_name = "download";
		download(1'b0);
		chk_i.test_name = "download_stall";
		download(1'b1);

		chk_i.test_name = "index_info";
		frame_q = '{FIO_FILE_INDEX, 16'($urandom)};
		send_frame(1);
		frame_q = '{FIO_FILE_INFO, 16'($urandom), 16'($urandom)};
		send_frame(1);
		frame_q = '{FIO_FILE_TX, 16'h00AA};
		send_frame(1);

		idle(10);
		$display("errors: %0d in %0d checks", errors, checks);
		if (errors == 0)
			$display("*** PASSED ***");
		else
			$display("*** FAILED ***");
		$finish;
	end

	// watchdog
	initial begin
		#(TIMEOUT_NS);
		$display("timeout: tests did not finish within %0d ns", TIMEOUT_NS);
		$display("*** FAILED ***");
		$finish;
	end

endmodule

`default_nettype wire
